//--- hw/alu_cluster_macros.svh
// ********************
// Integer ALU cluster
// Width, register file, queue and credit sizes
// ********************

`ifndef ALU_CLUSTER_MACROS_SVH
`define ALU_CLUSTER_MACROS_SVH

// Data path width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// Result queue entries and issuer credits after reset
`define RESULT_QUEUE_DEPTH 4

// Writeback credits granted by the consumer after reset
`define WB_CREDITS 2

`endif

//--- hw/alu_cluster_pkg.sv
// ********************
// Integer ALU cluster
// Shared word types and ALU command encoding
// ********************

`default_nettype none

`include "alu_cluster_macros.svh"

package alu_cluster_pkg;

    // Data word of the execution path
    typedef logic [`XLEN-1:0] xlen_word_t;

    // Raw RV32 instruction word
    typedef logic [31:0] instr_word_t;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // Commands understood by the ALU stage
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ILLEGAL
    } alu_cmd_t;

endpackage

`default_nettype wire

//--- hw/instr_decode.sv
// ********************
// Instruction decode stage
// Maps RV32 ALU words to commands, reads operands with bypass
// ********************

`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_macros.svh"

module instr_decode (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                i_instr_valid,
    input  wire alu_cluster_pkg::instr_word_t  i_instr,
    output alu_cluster_pkg::reg_addr_t         o_rf_rs1_addr,
    output alu_cluster_pkg::reg_addr_t         o_rf_rs2_addr,
    input  wire alu_cluster_pkg::xlen_word_t   i_rf_rs1_data,
    input  wire alu_cluster_pkg::xlen_word_t   i_rf_rs2_data,
    input  wire                                i_ex_valid,
    input  wire alu_cluster_pkg::reg_addr_t    i_ex_rd,
    input  wire alu_cluster_pkg::xlen_word_t   i_ex_data,
    input  wire                                i_ex_illegal,
    output logic                               o_dec_valid,
    output alu_cluster_pkg::alu_cmd_t          o_dec_cmd,
    output alu_cluster_pkg::reg_addr_t         o_dec_rd,
    output alu_cluster_pkg::reg_addr_t         o_dec_rs1,
    output alu_cluster_pkg::reg_addr_t         o_dec_rs2,
    output logic                               o_dec_rs2_used,
    output alu_cluster_pkg::xlen_word_t        o_dec_op_a,
    output alu_cluster_pkg::xlen_word_t        o_dec_op_b
);
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    alu_cluster_pkg::alu_cmd_t   cmd;
    logic                        rs2_used;
    logic                        ex_bypass_ok;
    alu_cluster_pkg::xlen_word_t imm;
    alu_cluster_pkg::xlen_word_t rs1_val;
    alu_cluster_pkg::xlen_word_t rs2_val;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // Sign-extended I-type immediate
    assign imm = {{(`XLEN - 12){i_instr[31]}}, i_instr[31:20]};

    assign rs2_used = (opcode == OPC_OP);

    always_comb begin
        cmd = alu_cluster_pkg::ALU_ILLEGAL;
        if (opcode == OPC_OP) begin
            case ({funct7, funct3})
                {7'b0000000, 3'b000}: cmd = alu_cluster_pkg::ALU_ADD;
                {7'b0100000, 3'b000}: cmd = alu_cluster_pkg::ALU_SUB;
                {7'b0000000, 3'b100}: cmd = alu_cluster_pkg::ALU_XOR;
                {7'b0000000, 3'b110}: cmd = alu_cluster_pkg::ALU_OR;
                {7'b0000000, 3'b111}: cmd = alu_cluster_pkg::ALU_AND;
                default:              cmd = alu_cluster_pkg::ALU_ILLEGAL;
            endcase
        end else if (opcode == OPC_OP_IMM) begin
            // RV32 has no SUBI so funct7 belongs to the immediate here
            case (funct3)
                3'b000:  cmd = alu_cluster_pkg::ALU_ADD;
                3'b100:  cmd = alu_cluster_pkg::ALU_XOR;
                3'b110:  cmd = alu_cluster_pkg::ALU_OR;
                3'b111:  cmd = alu_cluster_pkg::ALU_AND;
                default: cmd = alu_cluster_pkg::ALU_ILLEGAL;
            endcase
        end
    end

    assign o_rf_rs1_addr = i_instr[19:15];
    assign o_rf_rs2_addr = i_instr[24:20];

    // Distance-two bypass from the execute output
    assign ex_bypass_ok = i_ex_valid && !i_ex_illegal && (i_ex_rd != '0);
    assign rs1_val = (ex_bypass_ok && (i_ex_rd == o_rf_rs1_addr)) ? i_ex_data : i_rf_rs1_data;
    assign rs2_val = (ex_bypass_ok && (i_ex_rd == o_rf_rs2_addr)) ? i_ex_data : i_rf_rs2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_dec_valid <= 1'b0;
        end else begin
            o_dec_valid <= i_instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            o_dec_cmd      <= cmd;
            o_dec_rd       <= i_instr[11:7];
            o_dec_rs1      <= o_rf_rs1_addr;
            o_dec_rs2      <= o_rf_rs2_addr;
            o_dec_rs2_used <= rs2_used;
            o_dec_op_a     <= rs1_val;
            o_dec_op_b     <= rs2_used ? rs2_val : imm;
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_exec.sv
// ********************
// Registered ALU stage
// ADD, SUB, AND, OR, XOR with carry and illegal flags
// ********************

`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_macros.svh"

module alu_exec (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_dec_valid,
    input  wire alu_cluster_pkg::alu_cmd_t    i_dec_cmd,
    input  wire alu_cluster_pkg::reg_addr_t   i_dec_rd,
    input  wire alu_cluster_pkg::reg_addr_t   i_dec_rs1,
    input  wire alu_cluster_pkg::reg_addr_t   i_dec_rs2,
    input  wire                               i_dec_rs2_used,
    input  wire alu_cluster_pkg::xlen_word_t  i_dec_op_a,
    input  wire alu_cluster_pkg::xlen_word_t  i_dec_op_b,
    output logic                              o_ex_valid,
    output alu_cluster_pkg::reg_addr_t        o_ex_rd,
    output alu_cluster_pkg::xlen_word_t       o_ex_data,
    output logic                              o_ex_illegal,
    output logic                              o_ex_carry
);
    logic                        fwd_ok;
    alu_cluster_pkg::xlen_word_t op_a;
    alu_cluster_pkg::xlen_word_t op_b;
    logic [`XLEN:0]              wide_res;
    logic                        carry;

    // Distance-one forward from our own last result
    assign fwd_ok = o_ex_valid && !o_ex_illegal && (o_ex_rd != '0);
    assign op_a = (fwd_ok && (i_dec_rs1 == o_ex_rd)) ? o_ex_data : i_dec_op_a;
    assign op_b = (fwd_ok && i_dec_rs2_used && (i_dec_rs2 == o_ex_rd)) ? o_ex_data : i_dec_op_b;

    // One extra bit so the add/sub carry falls out on top
    always_comb begin
        carry = 1'b0;
        case (i_dec_cmd)
            alu_cluster_pkg::ALU_ADD: begin
                wide_res = {1'b0, op_a} + {1'b0, op_b};
                carry    = wide_res[`XLEN];
            end
            alu_cluster_pkg::ALU_SUB: begin
                wide_res = {1'b0, op_a} - {1'b0, op_b};
                carry    = wide_res[`XLEN];
            end
            alu_cluster_pkg::ALU_AND: wide_res = {1'b0, op_a & op_b};
            alu_cluster_pkg::ALU_OR:  wide_res = {1'b0, op_a | op_b};
            alu_cluster_pkg::ALU_XOR: wide_res = {1'b0, op_a ^ op_b};
            default:                  wide_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ex_valid <= 1'b0;
        end else begin
            o_ex_valid <= i_dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_dec_valid) begin
            o_ex_rd      <= i_dec_rd;
            o_ex_data    <= wide_res[`XLEN-1:0];
            o_ex_illegal <= (i_dec_cmd == alu_cluster_pkg::ALU_ILLEGAL);
            o_ex_carry   <= carry;
        end
    end

endmodule

`default_nettype wire

//--- hw/result_commit.sv
// ********************
// Result commit stage
// Register file, result queue and credit handling
// ********************

`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_macros.svh"

module result_commit (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_ex_valid,
    input  wire alu_cluster_pkg::reg_addr_t   i_ex_rd,
    input  wire alu_cluster_pkg::xlen_word_t  i_ex_data,
    input  wire                               i_ex_illegal,
    input  wire                               i_ex_carry,
    input  wire alu_cluster_pkg::reg_addr_t   i_rf_rs1_addr,
    input  wire alu_cluster_pkg::reg_addr_t   i_rf_rs2_addr,
    output alu_cluster_pkg::xlen_word_t       o_rf_rs1_data,
    output alu_cluster_pkg::xlen_word_t       o_rf_rs2_data,
    output logic                              o_issue_credit,
    output logic                              o_wb_valid,
    output alu_cluster_pkg::reg_addr_t        o_wb_rd,
    output alu_cluster_pkg::xlen_word_t       o_wb_data,
    output logic                              o_wb_illegal,
    output logic                              o_wb_carry,
    input  wire                               i_wb_credit
);
    localparam int QW  = $clog2(`RESULT_QUEUE_DEPTH);
    localparam int CW  = $clog2(`RESULT_QUEUE_DEPTH + 1);
    localparam int WCW = $clog2(`WB_CREDITS + 1);

    alu_cluster_pkg::xlen_word_t rf_mem [`REG_COUNT];
    alu_cluster_pkg::reg_addr_t  q_rd [`RESULT_QUEUE_DEPTH];
    alu_cluster_pkg::xlen_word_t q_data [`RESULT_QUEUE_DEPTH];
    logic                        q_illegal [`RESULT_QUEUE_DEPTH];
    logic                        q_carry [`RESULT_QUEUE_DEPTH];
    logic [QW-1:0]               wr_ptr;
    logic [QW-1:0]               rd_ptr;
    logic [CW-1:0]               q_count;
    logic [WCW-1:0]              wb_credit_cnt;
    logic                        rf_we;
    logic                        pop;

    // x0 is hardwired
    assign o_rf_rs1_data = (i_rf_rs1_addr == '0) ? '0 : rf_mem[i_rf_rs1_addr];
    assign o_rf_rs2_data = (i_rf_rs2_addr == '0) ? '0 : rf_mem[i_rf_rs2_addr];

    assign rf_we = i_ex_valid && !i_ex_illegal && (i_ex_rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                rf_mem[i] <= '0;
            end
        end else if (rf_we) begin
            rf_mem[i_ex_rd] <= i_ex_data;
        end
    end

    // Every result is queued including illegal ones
    always_ff @(posedge clk) begin
        if (i_ex_valid) begin
            q_rd[wr_ptr]      <= i_ex_rd;
            q_data[wr_ptr]    <= i_ex_data;
            q_illegal[wr_ptr] <= i_ex_illegal;
            q_carry[wr_ptr]   <= i_ex_carry;
        end
    end

    // Beat needs an entry and a downstream credit
    assign pop            = (q_count != '0) && (wb_credit_cnt != '0);
    assign o_wb_valid     = pop;
    assign o_issue_credit = pop;
    assign o_wb_rd        = q_rd[rd_ptr];
    assign o_wb_data      = q_data[rd_ptr];
    assign o_wb_illegal   = q_illegal[rd_ptr];
    assign o_wb_carry     = q_carry[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            q_count       <= '0;
            wb_credit_cnt <= WCW'(`WB_CREDITS);
        end else begin
            if (i_ex_valid) begin
                wr_ptr <= (wr_ptr == QW'(`RESULT_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QW'(`RESULT_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_ex_valid, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            // Returned pulse and spent beat may cancel out
            case ({i_wb_credit, pop})
                2'b10:   wb_credit_cnt <= wb_credit_cnt + 1'b1;
                2'b01:   wb_credit_cnt <= wb_credit_cnt - 1'b1;
                default: wb_credit_cnt <= wb_credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_cluster_top.sv
// ********************
// Integer ALU cluster top
// Decode, execute and commit with credit flow control
// ********************

`timescale 1ns/10ps
`default_nettype none

module alu_cluster_top (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_instr_valid,
    input  wire alu_cluster_pkg::instr_word_t i_instr,
    output logic                              o_issue_credit,
    output logic                              o_wb_valid,
    output alu_cluster_pkg::reg_addr_t        o_wb_rd,
    output alu_cluster_pkg::xlen_word_t       o_wb_data,
    output logic                              o_wb_illegal,
    output logic                              o_wb_carry,
    input  wire                               i_wb_credit
);
    // Decode to execute
    logic                        dec_valid;
    alu_cluster_pkg::alu_cmd_t   dec_cmd;
    alu_cluster_pkg::reg_addr_t  dec_rd;
    alu_cluster_pkg::reg_addr_t  dec_rs1;
    alu_cluster_pkg::reg_addr_t  dec_rs2;
    logic                        dec_rs2_used;
    alu_cluster_pkg::xlen_word_t dec_op_a;
    alu_cluster_pkg::xlen_word_t dec_op_b;

    // Execute to commit and the decode bypass
    logic                        ex_valid;
    alu_cluster_pkg::reg_addr_t  ex_rd;
    alu_cluster_pkg::xlen_word_t ex_data;
    logic                        ex_illegal;
    logic                        ex_carry;

    // Register file read ports
    alu_cluster_pkg::reg_addr_t  rf_rs1_addr;
    alu_cluster_pkg::reg_addr_t  rf_rs2_addr;
    alu_cluster_pkg::xlen_word_t rf_rs1_data;
    alu_cluster_pkg::xlen_word_t rf_rs2_data;

    instr_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_rf_rs1_addr  (rf_rs1_addr),
        .o_rf_rs2_addr  (rf_rs2_addr),
        .i_rf_rs1_data  (rf_rs1_data),
        .i_rf_rs2_data  (rf_rs2_data),
        .i_ex_valid     (ex_valid),
        .i_ex_rd        (ex_rd),
        .i_ex_data      (ex_data),
        .i_ex_illegal   (ex_illegal),
        .o_dec_valid    (dec_valid),
        .o_dec_cmd      (dec_cmd),
        .o_dec_rd       (dec_rd),
        .o_dec_rs1      (dec_rs1),
        .o_dec_rs2      (dec_rs2),
        .o_dec_rs2_used (dec_rs2_used),
        .o_dec_op_a     (dec_op_a),
        .o_dec_op_b     (dec_op_b)
    );

    alu_exec u_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_dec_valid    (dec_valid),
        .i_dec_cmd      (dec_cmd),
        .i_dec_rd       (dec_rd),
        .i_dec_rs1      (dec_rs1),
        .i_dec_rs2      (dec_rs2),
        .i_dec_rs2_used (dec_rs2_used),
        .i_dec_op_a     (dec_op_a),
        .i_dec_op_b     (dec_op_b),
        .o_ex_valid     (ex_valid),
        .o_ex_rd        (ex_rd),
        .o_ex_data      (ex_data),
        .o_ex_illegal   (ex_illegal),
        .o_ex_carry     (ex_carry)
    );

    result_commit u_commit (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_ex_valid     (ex_valid),
        .i_ex_rd        (ex_rd),
        .i_ex_data      (ex_data),
        .i_ex_illegal   (ex_illegal),
        .i_ex_carry     (ex_carry),
        .i_rf_rs1_addr  (rf_rs1_addr),
        .i_rf_rs2_addr  (rf_rs2_addr),
        .o_rf_rs1_data  (rf_rs1_data),
        .o_rf_rs2_data  (rf_rs2_data),
        .o_issue_credit (o_issue_credit),
        .o_wb_valid     (o_wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data),
        .o_wb_illegal   (o_wb_illegal),
        .o_wb_carry     (o_wb_carry),
        .i_wb_credit    (i_wb_credit)
    );

endmodule

`default_nettype wire

//--- verif/alu_cluster_checker.sv
// ********************
// Result commit checker
// Credit and queue invariants, bound into result_commit
// ********************

`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_macros.svh"

module alu_cluster_checker (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire [$clog2(`RESULT_QUEUE_DEPTH + 1)-1:0] i_q_count,
    input  wire [$clog2(`WB_CREDITS + 1)-1:0]         i_wb_credit_cnt,
    input  wire                                       i_wb_valid,
    input  wire                                       i_issue_credit,
    input  wire alu_cluster_pkg::reg_addr_t           i_wb_rd,
    input  wire alu_cluster_pkg::xlen_word_t          i_wb_data,
    input  wire                                       i_wb_illegal,
    input  wire                                       i_wb_carry
);
    a_queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
        i_q_count <= `RESULT_QUEUE_DEPTH)
        else $error("Result queue occupancy above its depth");

    // Consumer hands back only credits that beats have spent
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        i_wb_credit_cnt <= `WB_CREDITS)
        else $error("Writeback credit count above its initial grant");

    // Payload only matters while a beat is out
    a_known_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({i_wb_valid, i_issue_credit}) &&
        (i_wb_valid -> !$isunknown({i_wb_rd, i_wb_data, i_wb_illegal, i_wb_carry})))
        else $error("Unknown value on a writeback output");

endmodule

bind result_commit alu_cluster_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_q_count       (q_count),
    .i_wb_credit_cnt (wb_credit_cnt),
    .i_wb_valid      (o_wb_valid),
    .i_issue_credit  (o_issue_credit),
    .i_wb_rd         (o_wb_rd),
    .i_wb_data       (o_wb_data),
    .i_wb_illegal    (o_wb_illegal),
    .i_wb_carry      (o_wb_carry)
);

`default_nettype wire

//--- verif/alu_cluster_tb.sv
// ********************
// ALU cluster testbench
// Trace-driven issuer and random-credit consumer
// ********************

`timescale 1ns/10ps
`default_nettype none

`include "alu_cluster_macros.svh"

module alu_cluster_tb;
    localparam int TRACE_LEN    = 24;
    localparam int MAX_CYCLES   = 40 * TRACE_LEN;
    localparam int DRAIN_CYCLES = 16;

    logic                        clk;
    logic                        rst_n;
    logic                        instr_valid;
    alu_cluster_pkg::instr_word_t instr;
    logic                        issue_credit;
    logic                        wb_valid;
    alu_cluster_pkg::reg_addr_t  wb_rd;
    alu_cluster_pkg::xlen_word_t wb_data;
    logic                        wb_illegal;
    logic                        wb_carry;
    logic                        wb_credit;

    // Each entry is four words of instruction, rd, data and {illegal, carry}
    logic [31:0] trace_mem [4*TRACE_LEN];
    logic [7:0]  lfsr_state;
    int          issuer_credits;
    int          sent_count;
    int          rx_count;
    int          owed_credits;
    int          cycle_count;
    logic        rx_done;

    alu_cluster_top alu_cluster_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .o_issue_credit (issue_credit),
        .o_wb_valid     (wb_valid),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data),
        .o_wb_illegal   (wb_illegal),
        .o_wb_carry     (wb_carry),
        .i_wb_credit    (wb_credit)
    );

    always #2 clk = ~clk;

    // Galois LFSR x^8 + x^6 + x^5 + x^4 + 1 stepped once per bit drawn
    function automatic logic next_rand_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 8'hB8;
        end
        return out_bit;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_beat(input int idx);
        string tag;
        tag = $sformatf("entry_%0d", idx);
        check_field({tag, "_rd"}, trace_mem[4*idx+1], 32'(wb_rd));
        check_field({tag, "_data"}, trace_mem[4*idx+2], 32'(wb_data));
        check_field({tag, "_illegal"}, 32'(trace_mem[4*idx+3][1]), 32'(wb_illegal));
        check_field({tag, "_carry"}, 32'(trace_mem[4*idx+3][0]), 32'(wb_carry));
    endtask

    // Issuer and consumer share one clocked block so the draw order is fixed
    always @(posedge clk) begin
        logic gate_issue;
        logic take_a;
        logic take_b;
        logic send;
        gate_issue = next_rand_bit();
        take_a     = next_rand_bit();
        take_b     = next_rand_bit();
        if (rst_n) begin
            // Consumer side checks beats in trace order
            if (wb_valid) begin
                if (rx_count >= TRACE_LEN) begin
                    $display("Writeback beat seen after the last trace entry");
                    abort_run();
                end else begin
                    check_beat(rx_count);
                    rx_count++;
                    owed_credits++;
                end
            end
            if (owed_credits > 0 && take_a && take_b) begin
                wb_credit <= 1'b1;
                owed_credits--;
            end else begin
                wb_credit <= 1'b0;
            end
            if (rx_count == TRACE_LEN) begin
                rx_done = 1'b1;
            end

            // Issuer side
            if (issue_credit) begin
                issuer_credits++;
            end
            send = gate_issue && (issuer_credits > 0) && (sent_count < TRACE_LEN);
            instr_valid <= send;
            instr       <= send ? trace_mem[4*sent_count] : '0;
            if (send) begin
                sent_count++;
                issuer_credits--;
            end
            assert (sent_count - rx_count <= `RESULT_QUEUE_DEPTH) else begin
                $display("More instructions outstanding than the result queue holds");
                abort_run();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     MAX_CYCLES, rx_count, TRACE_LEN);
            abort_run();
        end
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        wb_credit      = 1'b0;
        lfsr_state     = 8'd31;
        issuer_credits = `RESULT_QUEUE_DEPTH;
        sent_count     = 0;
        rx_count       = 0;
        owed_credits   = 0;
        cycle_count    = 0;
        rx_done        = 1'b0;
        $readmemh("verif/alu_cluster_trace.txt", trace_mem);
        if ($isunknown(trace_mem[4*TRACE_LEN-1])) begin
            $display("Trace file is missing or shorter than %0d entries", TRACE_LEN);
            abort_run();
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (rx_done);
        // Some idle cycles so a duplicate beat would still be caught
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/alu_cluster_trace.txt
// Per line: instruction word, expected rd, expected data, flags {illegal, carry}
// Entries are read as consecutive 32-bit words, four per instruction
00500093 01 00000005 0
fff00113 02 ffffffff 0
7f006193 03 000007f0 0
80004213 04 fffff800 0
7ff07293 05 00000000 0
00208333 06 00000004 1
401303b3 07 ffffffff 1
0063c433 08 fffffffb 0
0061e4b3 09 000007f4 0
00447533 0a fffff800 0
002105b3 0b fffffffe 1
40608633 0c 00000001 0
00002083 01 00000000 2
022081b3 03 00000000 2
00008693 0d 00000005 0
0001e733 0e 000007f0 0
00908013 00 0000000e 0
000007b3 0f 00000000 0
12304813 10 00000123 0
00f808b3 11 00000123 0
41088933 12 00000000 0
7ff00993 13 000007ff 0
00a98a33 14 ffffffff 0
00109a93 15 00000000 2

//--- alu_cluster_top.f
+incdir+hw
hw/alu_cluster_pkg.sv
hw/instr_decode.sv
hw/alu_exec.sv
hw/result_commit.sv
hw/alu_cluster_top.sv
verif/alu_cluster_checker.sv
verif/alu_cluster_tb.sv

//--- Bender.yml
package:
  name: alu_cluster

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/alu_cluster_pkg.sv
      - hw/instr_decode.sv
      - hw/alu_exec.sv
      - hw/result_commit.sv
      - hw/alu_cluster_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/alu_cluster_checker.sv
      - verif/alu_cluster_tb.sv
